/* vlog.f */
+incdir+testbench
hw/mos_pkg.sv
hw/decoder.sv
hw/addr_unit.sv
hw/exec_unit.sv
hw/cpu_core.sv
testbench/tb_cpu_core.sv

/* run.sh */
#!/usr/bin/env bash
# builds the cpu_core testbench with verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_cpu_core -o sim_tb_cpu_core

./obj_dir/sim_tb_cpu_core | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
        echo "run.sh: simulation ok"
        exit 0
else
        echo "run.sh: simulation reported failure"
        exit 1
fi

/* testbench/tb_vectors.svh */
/*
 * directed instruction table included by the cpu_core testbench.
 * each entry gives one instruction and the A, X, flags and illegal expected at its done pulse
 */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

typedef struct packed {
        logic [mos_pkg::REG_WIDTH-1:0] opcode;
        logic [mos_pkg::REG_WIDTH-1:0] operand;
        logic [mos_pkg::REG_WIDTH-1:0] a;
        logic [mos_pkg::REG_WIDTH-1:0] x;
        logic                          n;
        logic                          z;
        logic                          c;
        logic                          ill;
} vector_t;

localparam int NUM_VECTORS = 39;

// columns are opcode, operand, a, x, n, z, c, illegal
localparam vector_t VECTORS [NUM_VECTORS] = '{
        '{8'hA9, 8'h00, 8'h00, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0},      // lda #00
        '{8'hA9, 8'h80, 8'h80, 8'h00, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'hA2, 8'h7F, 8'h80, 8'h7F, 1'b0, 1'b0, 1'b0, 1'b0},      // ldx #7f
        '{8'hA2, 8'h00, 8'h80, 8'h00, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'hA9, 8'h5A, 8'h5A, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'h85, 8'h10, 8'h5A, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0},      // sta $10
        '{8'hA2, 8'hC3, 8'h5A, 8'hC3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h86, 8'h20, 8'h5A, 8'hC3, 1'b1, 1'b0, 1'b0, 1'b0},      // stx $20
        '{8'hA9, 8'h00, 8'h00, 8'hC3, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'hA5, 8'h10, 8'h5A, 8'hC3, 1'b0, 1'b0, 1'b0, 1'b0},      // lda $10
        '{8'hA5, 8'h20, 8'hC3, 8'hC3, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'hA6, 8'h10, 8'hC3, 8'h5A, 1'b0, 1'b0, 1'b0, 1'b0},      // ldx $10
        '{8'h95, 8'hF0, 8'hC3, 8'h5A, 1'b0, 1'b0, 1'b0, 1'b0},      // sta $f0,x lands on $4a
        '{8'hA9, 8'h00, 8'h00, 8'h5A, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'hA5, 8'h4A, 8'hC3, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h09, 8'h0C, 8'hCF, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},      // ora #0c
        '{8'h29, 8'h30, 8'h00, 8'h5A, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'h09, 8'hF0, 8'hF0, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h25, 8'h10, 8'h50, 8'h5A, 1'b0, 1'b0, 1'b0, 1'b0},      // and $10
        '{8'h45, 8'h20, 8'h93, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h49, 8'h93, 8'h00, 8'h5A, 1'b0, 1'b1, 1'b0, 1'b0},
        '{8'h15, 8'hF0, 8'hC3, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},      // ora $f0,x
        '{8'h35, 8'hB6, 8'h42, 8'h5A, 1'b0, 1'b0, 1'b0, 1'b0},      // $b6+x wraps to $10
        '{8'h55, 8'hC6, 8'h81, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'hA9, 8'hFF, 8'hFF, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h69, 8'h01, 8'h00, 8'h5A, 1'b0, 1'b1, 1'b1, 1'b0},      // ff + 01 carries out
        '{8'h69, 8'h00, 8'h01, 8'h5A, 1'b0, 1'b0, 1'b0, 1'b0},      // carry chains in
        '{8'h65, 8'h10, 8'h5B, 8'h5A, 1'b0, 1'b0, 1'b0, 1'b0},
        '{8'h69, 8'hB0, 8'h0B, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b0},
        '{8'h75, 8'hC6, 8'hCF, 8'h5A, 1'b1, 1'b0, 1'b0, 1'b0},
        '{8'h69, 8'h40, 8'h0F, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b0},
        '{8'h29, 8'h0F, 8'h0F, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b0},      // logic keeps C
        '{8'h82, 8'h77, 8'h0F, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b1},      // stx #imm
        '{8'h89, 8'h30, 8'h0F, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b1},
        '{8'hA7, 8'h10, 8'h0F, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b1},      // cc = 11
        '{8'hC9, 8'h00, 8'h0F, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b1},      // aaa 110
        '{8'h96, 8'h4A, 8'h0F, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b1},
        '{8'hA5, 8'h4A, 8'hC3, 8'h5A, 1'b1, 1'b0, 1'b1, 1'b0},      // $4a untouched by $96
        '{8'hA5, 8'h10, 8'h5A, 8'h5A, 1'b0, 1'b0, 1'b1, 1'b0}
};

`endif

/* testbench/tb_cpu_core.sv */
/*
 * drives cpu_core through the directed table in tb_vectors.svh and then a random sequence
 * checked against a reference model
 */
`timescale 1ns/10ps
`default_nettype none

module tb_cpu_core;

        `include "tb_vectors.svh"

        localparam int NUM_RANDOM     = 200;
        localparam int TIMEOUT_CYCLES = (NUM_VECTORS + NUM_RANDOM) * 4 + 100;
        localparam int POOL_SIZE      = 28;

        // 20 legal opcodes followed by 8 illegal ones
        localparam logic [7:0] OPCODE_POOL [POOL_SIZE] = '{
                8'hA9, 8'hA5, 8'hB5, 8'hA2, 8'hA6, 8'h85, 8'h95, 8'h86, 8'h09, 8'h05,
                8'h15, 8'h29, 8'h25, 8'h35, 8'h49, 8'h45, 8'h55, 8'h69, 8'h65, 8'h75,
                8'h82, 8'h89, 8'hA7, 8'hC9, 8'h96, 8'hFF, 8'hE9, 8'h00
        };

        logic                          clk;
        logic                          reset_n;
        logic                          instruction_ready;
        logic [mos_pkg::REG_WIDTH-1:0] instruction_in;
        logic [mos_pkg::REG_WIDTH-1:0] operand_in;
        logic [mos_pkg::REG_WIDTH-1:0] a_out;
        logic [mos_pkg::REG_WIDTH-1:0] x_out;
        logic                          flag_n;
        logic                          flag_z;
        logic                          flag_c;
        logic                          instruction_done;
        logic                          illegal;

        int          value_errors = 0;
        int          proto_errors = 0;
        int          cycle_count  = 0;
        int          step         = 0;
        logic [31:0] lfsr_state;

        // reference model state
        logic [7:0] m_a;
        logic [7:0] m_x;
        logic       m_n;
        logic       m_z;
        logic       m_c;
        logic       m_ill;
        logic [7:0] m_mem [256];
        bit         m_written [256];

        cpu_core u_cpu_core (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .instruction_in    (instruction_in),
                .operand_in        (operand_in),
                .a_out             (a_out),
                .x_out             (x_out),
                .flag_n            (flag_n),
                .flag_z            (flag_z),
                .flag_c            (flag_c),
                .instruction_done  (instruction_done),
                .illegal           (illegal)
        );

        always #50 clk = ~clk;

        always @(posedge clk) begin
                cycle_count = cycle_count + 1;
                if (cycle_count >= TIMEOUT_CYCLES) begin
                        $display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
                        $display("*** FAILED ***");
                        $finish;
                end
        end

        task automatic check_byte(input string name, input logic [mos_pkg::REG_WIDTH-1:0] expected,
                                  input logic [mos_pkg::REG_WIDTH-1:0] actual);
                if (actual !== expected) begin
                        $display("Error: %s expected %h got %h at step %0d",
                                 name, expected, actual, step);
                        value_errors++;
                end
        endtask

        task automatic check_flag(input string name, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("Error: %s expected %h got %h at step %0d",
                                 name, expected, actual, step);
                        value_errors++;
                end
        endtask

        task automatic check_outputs(input logic [7:0] a, input logic [7:0] x, input logic n,
                                     input logic z, input logic c, input logic ill);
                check_byte("a_out", a, a_out);
                check_byte("x_out", x, x_out);
                check_flag("flag_n", n, flag_n);
                check_flag("flag_z", z, flag_z);
                check_flag("flag_c", c, flag_c);
                check_flag("illegal", ill, illegal);
        endtask

        // starts 5 ns after a rising edge and returns at the falling edge inside the done cycle
        task automatic run_instr(input logic [7:0] op, input logic [7:0] opnd);
                int  waits;
                bit  seen;
                waits = 0;
                seen  = 1'b0;
                instruction_in    = op;
                operand_in        = opnd;
                instruction_ready = 1'b1;
                @(posedge clk);
                #5;
                instruction_ready = 1'b0;
                instruction_in    = '0;
                operand_in        = '0;
                while (!seen && waits < 4) begin
                        @(negedge clk);
                        waits++;
                        if (instruction_done === 1'b1)
                                seen = 1'b1;
                end
                if (!seen) begin
                        $display("no done pulse within 4 cycles for opcode %h at step %0d",
                                 op, step);
                        proto_errors++;
                end else if (waits != 2) begin
                        $display("done came %0d cycles after the strobe at step %0d", waits, step);
                        proto_errors++;
                end
        endtask

        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
        endfunction

        task automatic draw_bits(input int count, output logic [7:0] value);
                value = '0;
                for (int i = 0; i < count; i++) begin
                        lfsr_state = lfsr_next(lfsr_state);
                        value = {value[6:0], lfsr_state[0]};
                end
        endtask

        function automatic bit reads_memory(input logic [7:0] op);
                case (op)
                8'hA5, 8'hB5, 8'hA6, 8'h05, 8'h15, 8'h25, 8'h35,
                8'h45, 8'h55, 8'h65, 8'h75: return 1'b1;
                default:                     return 1'b0;
                endcase
        endfunction

        task automatic set_nz(input logic [7:0] v);
                m_n = v[7];
                m_z = (v == 8'h00);
        endtask

        // 6502 semantics for the supported subset
        task automatic model_step(input logic [7:0] op, input logic [7:0] opnd);
                logic [7:0] addr;
                logic [7:0] b;
                logic [8:0] total;
                addr  = op[4] ? opnd + m_x : opnd;      // the zp,x opcodes have bit 4 set
                b     = (op[3:0] == 4'h9) ? opnd : m_mem[addr];
                total = {1'b0, m_a} + {1'b0, b} + {8'h00, m_c};
                m_ill = 1'b0;
                case (op)
                8'hA9, 8'hA5, 8'hB5: begin
                        m_a = b;
                        set_nz(m_a);
                end
                8'hA2: begin
                        m_x = opnd;
                        set_nz(m_x);
                end
                8'hA6: begin
                        m_x = m_mem[addr];
                        set_nz(m_x);
                end
                8'h85, 8'h95: begin
                        m_mem[addr]     = m_a;
                        m_written[addr] = 1'b1;
                end
                8'h86: begin
                        m_mem[addr]     = m_x;
                        m_written[addr] = 1'b1;
                end
                8'h09, 8'h05, 8'h15: begin
                        m_a = m_a | b;
                        set_nz(m_a);
                end
                8'h29, 8'h25, 8'h35: begin
                        m_a = m_a & b;
                        set_nz(m_a);
                end
                8'h49, 8'h45, 8'h55: begin
                        m_a = m_a ^ b;
                        set_nz(m_a);
                end
                8'h69, 8'h65, 8'h75: begin
                        m_a = total[7:0];
                        m_c = total[8];
                        set_nz(m_a);
                end
                default: m_ill = 1'b1;
                endcase
        endtask

        initial begin
                logic [7:0] pick;
                logic [7:0] op;
                logic [7:0] opnd;
                logic [7:0] addr;
                clk               = 1'b0;
                reset_n           = 1'b0;
                instruction_ready = 1'b0;
                instruction_in    = '0;
                operand_in        = '0;
                lfsr_state        = 32'h61b3_3855;

                repeat (10) @(posedge clk);
                #5;
                reset_n = 1'b1;
                @(posedge clk);
                #5;
                check_outputs(8'h00, 8'h00, 1'b0, 1'b0, 1'b0, 1'b0);
                check_flag("instruction_done", 1'b0, instruction_done);

                for (int i = 0; i < NUM_VECTORS; i++) begin
                        step = i;
                        run_instr(VECTORS[i].opcode, VECTORS[i].operand);
                        check_outputs(VECTORS[i].a, VECTORS[i].x, VECTORS[i].n,
                                      VECTORS[i].z, VECTORS[i].c, VECTORS[i].ill);
                        @(posedge clk);
                        #5;
                end

                // model picks up where the table left the registers and treats memory as unknown
                m_a = VECTORS[NUM_VECTORS-1].a;
                m_x = VECTORS[NUM_VECTORS-1].x;
                m_n = VECTORS[NUM_VECTORS-1].n;
                m_z = VECTORS[NUM_VECTORS-1].z;
                m_c = VECTORS[NUM_VECTORS-1].c;
                for (int i = 0; i < 256; i++)
                        m_written[i] = 1'b0;

                for (int i = 0; i < NUM_RANDOM; i++) begin
                        step = NUM_VECTORS + i;
                        draw_bits(5, pick);
                        draw_bits(8, opnd);
                        op   = OPCODE_POOL[int'(pick) % POOL_SIZE];
                        addr = op[4] ? opnd + m_x : opnd;
                        if (reads_memory(op) && !m_written[addr]) begin
                                op   = 8'h85;           // write the byte before anything reads it
                                opnd = addr;
                        end
                        model_step(op, opnd);
                        run_instr(op, opnd);
                        check_outputs(m_a, m_x, m_n, m_z, m_c, m_ill);
                        @(posedge clk);
                        #5;
                end

                $display("value errors: %0d, protocol errors: %0d", value_errors, proto_errors);
                if (value_errors == 0 && proto_errors == 0)
                        $display("*** PASSED ***");
                else
                        $display("*** FAILED ***");
                $finish;
        end

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
/*
 * top of the 6502-style core slice: decoder, address unit and execution unit.
 * one instruction per strobe, done pulses two cycles after the strobe edge
 */
`timescale 1ns/10ps
`default_nettype none

module cpu_core (
        input  logic                            clk,
        input  logic                            reset_n,
        input  logic                            instruction_ready,
        input  logic [mos_pkg::REG_WIDTH-1:0]   instruction_in,
        input  logic [mos_pkg::REG_WIDTH-1:0]   operand_in,
        output logic [mos_pkg::REG_WIDTH-1:0]   a_out,
        output logic [mos_pkg::REG_WIDTH-1:0]   x_out,
        output logic                            flag_n,
        output logic                            flag_z,
        output logic                            flag_c,
        output logic                            instruction_done,
        output logic                            illegal
);

        mos_pkg::opp_e                  opp;
        mos_pkg::am_e                   add_mode;
        logic [mos_pkg::WE_WIDTH-1:0]   we;
        mos_pkg::sel_e                  sel;
        logic                           exec_en;
        logic [mos_pkg::REG_WIDTH-1:0]  imm_value;
        logic [mos_pkg::REG_WIDTH-1:0]  eff_addr;

        decoder u_decoder (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .instruction_in    (instruction_in),
                .opp               (opp),
                .add_mode          (add_mode),
                .we                (we),
                .sel               (sel),
                .exec_en           (exec_en),
                .instruction_done  (instruction_done),
                .illegal           (illegal)
        );

        addr_unit u_addr_unit (
                .clk               (clk),
                .reset_n           (reset_n),
                .instruction_ready (instruction_ready),
                .exec_en           (exec_en),
                .operand_in        (operand_in),
                .x_in              (x_out),             // index comes straight from X
                .add_mode          (add_mode),
                .imm_value         (imm_value),
                .eff_addr          (eff_addr)
        );

        exec_unit u_exec_unit (
                .clk               (clk),
                .reset_n           (reset_n),
                .exec_en           (exec_en),
                .opp               (opp),
                .we                (we),
                .sel               (sel),
                .imm_value         (imm_value),
                .eff_addr          (eff_addr),
                .a_out             (a_out),
                .x_out             (x_out),
                .flag_n            (flag_n),
                .flag_z            (flag_z),
                .flag_c            (flag_c)
        );

endmodule

`default_nettype wire

/* hw/exec_unit.sv */
/*
 * execution unit: A and X registers, N/Z/C flags, zero-page ram and the alu.
 * carries out the decoded operation during exec_en, results land on the closing edge
 */
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
        input  logic                            clk,
        input  logic                            reset_n,
        input  logic                            exec_en,
        input  mos_pkg::opp_e                   opp,
        input  logic [mos_pkg::WE_WIDTH-1:0]    we,
        input  mos_pkg::sel_e                   sel,
        input  logic [mos_pkg::REG_WIDTH-1:0]   imm_value,
        input  logic [mos_pkg::REG_WIDTH-1:0]   eff_addr,
        output logic [mos_pkg::REG_WIDTH-1:0]   a_out,
        output logic [mos_pkg::REG_WIDTH-1:0]   x_out,
        output logic                            flag_n,
        output logic                            flag_z,
        output logic                            flag_c
);

        logic [mos_pkg::REG_WIDTH-1:0] a_q;
        logic [mos_pkg::REG_WIDTH-1:0] x_q;
        logic                          n_q;
        logic                          z_q;
        logic                          c_q;

        logic [mos_pkg::REG_WIDTH-1:0] zp_mem [mos_pkg::ZP_DEPTH];

        logic [mos_pkg::REG_WIDTH-1:0] mem_rd;
        logic [mos_pkg::REG_WIDTH-1:0] operand_b;
        logic [mos_pkg::REG_WIDTH:0]   sum;
        logic [mos_pkg::REG_WIDTH-1:0] alu_res;
        logic                          is_alu;
        mos_pkg::sel_e                 dst_sel;
        logic [mos_pkg::REG_WIDTH-1:0] wr_data;
        logic                          wr_reg;

        assign mem_rd    = zp_mem[eff_addr];                            // async read
        assign operand_b = (sel == mos_pkg::SEL_IMM) ? imm_value : mem_rd;

        assign is_alu = (opp == mos_pkg::OPP_ORA) || (opp == mos_pkg::OPP_AND) ||
                        (opp == mos_pkg::OPP_EOR) || (opp == mos_pkg::OPP_ADC);

        assign sum = {1'b0, a_q} + {1'b0, operand_b} + {{mos_pkg::REG_WIDTH{1'b0}}, c_q};

        always_comb begin
                case (opp)
                mos_pkg::OPP_ORA: alu_res = a_q | operand_b;
                mos_pkg::OPP_AND: alu_res = a_q & operand_b;
                mos_pkg::OPP_EOR: alu_res = a_q ^ operand_b;
                mos_pkg::OPP_ADC: alu_res = sum[mos_pkg::REG_WIDTH-1:0];
                default:          alu_res = operand_b;
                endcase
        end

        // alu ops override the operand source in sel
        assign dst_sel = is_alu ? mos_pkg::SEL_ALU : sel;

        always_comb begin
                case (dst_sel)
                mos_pkg::SEL_A:   wr_data = a_q;
                mos_pkg::SEL_X:   wr_data = x_q;
                mos_pkg::SEL_ALU: wr_data = alu_res;
                default:          wr_data = operand_b;          // loads, imm or mem
                endcase
        end

        assign wr_reg = we[mos_pkg::WE_A] | we[mos_pkg::WE_X];

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        a_q <= '0;
                        x_q <= '0;
                        n_q <= 1'b0;
                        z_q <= 1'b0;
                        c_q <= 1'b0;
                end else if (exec_en) begin
                        if (we[mos_pkg::WE_A])
                                a_q <= wr_data;
                        if (we[mos_pkg::WE_X])
                                x_q <= wr_data;
                        if (wr_reg) begin                       // stores keep the flags
                                n_q <= wr_data[mos_pkg::REG_WIDTH-1];
                                z_q <= (wr_data == '0);
                        end
                        if (opp == mos_pkg::OPP_ADC)
                                c_q <= sum[mos_pkg::REG_WIDTH];
                end
        end

        always_ff @(posedge clk) begin
                if (exec_en && we[mos_pkg::WE_MEM])
                        zp_mem[eff_addr] <= wr_data;
        end

        assign a_out  = a_q;
        assign x_out  = x_q;
        assign flag_n = n_q;
        assign flag_z = z_q;
        assign flag_c = c_q;

        // address from addr_unit must be known whenever ram is touched
        a_addr_known: assert property (@(posedge clk) disable iff (!reset_n)
                exec_en && (we[mos_pkg::WE_MEM] || sel == mos_pkg::SEL_MEM)
                |-> !$isunknown(eff_addr))
                else $error("zero-page access with unknown address");

endmodule

`default_nettype wire

/* hw/addr_unit.sv */
/*
 * operand latch and zero-page address former.
 * operand is captured on the strobe, eff_addr is valid combinationally while exec_en is high
 */
`timescale 1ns/10ps
`default_nettype none

module addr_unit (
        input  logic                            clk,
        input  logic                            reset_n,
        input  logic                            instruction_ready,
        input  logic                            exec_en,
        input  logic [mos_pkg::REG_WIDTH-1:0]   operand_in,
        input  logic [mos_pkg::REG_WIDTH-1:0]   x_in,
        input  mos_pkg::am_e                    add_mode,
        output logic [mos_pkg::REG_WIDTH-1:0]   imm_value,
        output logic [mos_pkg::REG_WIDTH-1:0]   eff_addr
);

        logic [mos_pkg::REG_WIDTH-1:0] operand_q;

        // operand only valid in the strobe cycle
        always_ff @(posedge clk) begin
                if (!reset_n)
                        operand_q <= '0;
                else if (instruction_ready)
                        operand_q <= operand_in;
        end

        assign imm_value = operand_q;

        always_comb begin
                case (add_mode)
                mos_pkg::AM_ZPG_X: eff_addr = operand_q + x_in;     // wraps inside page 0
                default:           eff_addr = operand_q;
                endcase
        end

        // indexed access needs a known x from exec_unit
        a_x_known: assert property (@(posedge clk) disable iff (!reset_n)
                exec_en && add_mode == mos_pkg::AM_ZPG_X |-> !$isunknown(x_in))
                else $error("indexed access with unknown x");

endmodule

`default_nettype wire

/* hw/decoder.sv */
/*
 * opcode decoder and instruction sequencer.
 * takes one opcode per instruction_ready strobe, runs one execute cycle, then pulses done
 */
`timescale 1ns/10ps
`default_nettype none

module decoder (
        input  logic                            clk,
        input  logic                            reset_n,
        input  logic                            instruction_ready,
        input  logic [mos_pkg::REG_WIDTH-1:0]   instruction_in,
        output mos_pkg::opp_e                   opp,
        output mos_pkg::am_e                    add_mode,
        output logic [mos_pkg::WE_WIDTH-1:0]    we,
        output mos_pkg::sel_e                   sel,
        output logic                            exec_en,
        output logic                            instruction_done,
        output logic                            illegal
);

        mos_pkg::dec_state_e state;

        logic [2:0] aaa;
        logic [2:0] bbb;
        logic [1:0] cc;

        mos_pkg::opp_e                  dec_opp;
        mos_pkg::am_e                   dec_mode;
        logic [mos_pkg::WE_WIDTH-1:0]   dec_we;
        mos_pkg::sel_e                  dec_sel;
        logic                           dec_ok;

        assign aaa = instruction_in[mos_pkg::AAA_HI:mos_pkg::AAA_LO];
        assign bbb = instruction_in[mos_pkg::BBB_HI:mos_pkg::BBB_LO];
        assign cc  = instruction_in[mos_pkg::CC_HI:mos_pkg::CC_LO];

        always_comb begin
                dec_opp  = mos_pkg::OPP_NOP;
                dec_mode = mos_pkg::AM_IMM;
                dec_we   = '0;
                dec_sel  = mos_pkg::SEL_IMM;
                dec_ok   = 1'b0;

                case (cc)
                mos_pkg::CC_GRP1: begin
                        dec_ok = 1'b1;
                        case (bbb)
                        mos_pkg::BBB1_IMM:   dec_mode = mos_pkg::AM_IMM;
                        mos_pkg::BBB1_ZPG:   dec_mode = mos_pkg::AM_ZPG;
                        mos_pkg::BBB1_ZPG_X: dec_mode = mos_pkg::AM_ZPG_X;
                        default:             dec_ok = 1'b0;
                        endcase
                        case (aaa)
                        3'b000:  dec_opp = mos_pkg::OPP_ORA;
                        3'b001:  dec_opp = mos_pkg::OPP_AND;
                        3'b010:  dec_opp = mos_pkg::OPP_EOR;
                        3'b011:  dec_opp = mos_pkg::OPP_ADC;
                        3'b100:  dec_opp = mos_pkg::OPP_STA;
                        3'b101:  dec_opp = mos_pkg::OPP_LDA;
                        default: dec_ok = 1'b0;
                        endcase
                        // 0x89 has no store target, a nop on the real part too
                        if (aaa == 3'b100 && bbb == mos_pkg::BBB1_IMM)
                                dec_ok = 1'b0;
                end
                mos_pkg::CC_GRP2: begin
                        dec_ok = 1'b1;
                        case (aaa)
                        3'b100:  dec_opp = mos_pkg::OPP_STX;
                        3'b101:  dec_opp = mos_pkg::OPP_LDX;
                        default: dec_ok = 1'b0;
                        endcase
                        case (bbb)
                        mos_pkg::BBB2_IMM: dec_mode = mos_pkg::AM_IMM;
                        mos_pkg::BBB2_ZPG: dec_mode = mos_pkg::AM_ZPG;
                        default:           dec_ok = 1'b0;
                        endcase
                        if (aaa == 3'b100 && bbb == mos_pkg::BBB2_IMM)
                                dec_ok = 1'b0;          // stx imm
                end
                default: ;
                endcase

                if (!dec_ok) begin
                        dec_opp  = mos_pkg::OPP_NOP;
                        dec_mode = mos_pkg::AM_IMM;
                end

                // alu ops carry their operand source in sel, exec_unit routes the result
                case (dec_opp)
                mos_pkg::OPP_ORA, mos_pkg::OPP_AND, mos_pkg::OPP_EOR, mos_pkg::OPP_ADC,
                mos_pkg::OPP_LDA: begin
                        dec_we[mos_pkg::WE_A] = 1'b1;
                        dec_sel = (dec_mode == mos_pkg::AM_IMM) ? mos_pkg::SEL_IMM
                                                                : mos_pkg::SEL_MEM;
                end
                mos_pkg::OPP_LDX: begin
                        dec_we[mos_pkg::WE_X] = 1'b1;
                        dec_sel = (dec_mode == mos_pkg::AM_IMM) ? mos_pkg::SEL_IMM
                                                                : mos_pkg::SEL_MEM;
                end
                mos_pkg::OPP_STA: begin
                        dec_we[mos_pkg::WE_MEM] = 1'b1;
                        dec_sel = mos_pkg::SEL_A;
                end
                mos_pkg::OPP_STX: begin
                        dec_we[mos_pkg::WE_MEM] = 1'b1;
                        dec_sel = mos_pkg::SEL_X;
                end
                default: ;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!reset_n) begin
                        state    <= mos_pkg::ST_IDLE;
                        opp      <= mos_pkg::OPP_NOP;
                        add_mode <= mos_pkg::AM_IMM;
                        we       <= '0;
                        sel      <= mos_pkg::SEL_IMM;
                        illegal  <= 1'b0;
                end else begin
                        case (state)
                        mos_pkg::ST_IDLE: begin
                                if (instruction_ready) begin
                                        opp      <= dec_opp;
                                        add_mode <= dec_mode;
                                        we       <= dec_we;
                                        sel      <= dec_sel;
                                        illegal  <= !dec_ok;
                                        state    <= mos_pkg::ST_EXEC;
                                end
                        end
                        mos_pkg::ST_EXEC: begin
                                opp   <= mos_pkg::OPP_NOP;      // controls drop after execute
                                we    <= '0;
                                sel   <= mos_pkg::SEL_IMM;
                                state <= mos_pkg::ST_DONE;
                        end
                        default: state <= mos_pkg::ST_IDLE;
                        endcase
                end
        end

        assign exec_en          = (state == mos_pkg::ST_EXEC);
        assign instruction_done = (state == mos_pkg::ST_DONE);

        // host must wait for done before the next strobe
        a_strobe_idle: assert property (@(posedge clk) disable iff (!reset_n)
                instruction_ready |-> state == mos_pkg::ST_IDLE)
                else $error("instruction_ready while decoder busy");

        a_we_onehot: assert property (@(posedge clk) disable iff (!reset_n)
                $onehot0(we))
                else $error("more than one write enable set");

endmodule

`default_nettype wire

/* hw/mos_pkg.sv */
/*
 * shared widths, opcode field positions and enums for the 6502-style core slice.
 * every rtl file refers to these by scoped name
 */
`default_nettype none

package mos_pkg;

        localparam int REG_WIDTH = 8;
        localparam int ZP_DEPTH  = 256;

        // opcode byte is aaa_bbb_cc
        localparam int AAA_HI = 7;
        localparam int AAA_LO = 5;
        localparam int BBB_HI = 4;
        localparam int BBB_LO = 2;
        localparam int CC_HI  = 1;
        localparam int CC_LO  = 0;

        localparam logic [1:0] CC_GRP1 = 2'b01;     // ora/and/eor/adc/sta/lda
        localparam logic [1:0] CC_GRP2 = 2'b10;     // stx/ldx

        // bbb codes, group 1
        localparam logic [2:0] BBB1_IMM   = 3'b010;
        localparam logic [2:0] BBB1_ZPG   = 3'b001;
        localparam logic [2:0] BBB1_ZPG_X = 3'b101;
        // bbb codes, group 2
        localparam logic [2:0] BBB2_IMM   = 3'b000;
        localparam logic [2:0] BBB2_ZPG   = 3'b001;

        // write enable vector bits
        localparam int WE_A     = 0;
        localparam int WE_X     = 1;
        localparam int WE_MEM   = 2;
        localparam int WE_WIDTH = 3;

        typedef enum logic [3:0] {
                OPP_NOP, OPP_ORA, OPP_AND, OPP_EOR, OPP_ADC,
                OPP_STA, OPP_STX, OPP_LDA, OPP_LDX
        } opp_e;

        typedef enum logic [1:0] {
                AM_IMM, AM_ZPG, AM_ZPG_X
        } am_e;

        // source of the value written to the destination
        typedef enum logic [2:0] {
                SEL_IMM, SEL_MEM, SEL_A, SEL_X, SEL_ALU
        } sel_e;

        typedef enum logic [1:0] {
                ST_IDLE, ST_EXEC, ST_DONE
        } dec_state_e;

endpackage

`default_nettype wire
